/* miniSrc.f */
verilog/miniSrcPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/miniSrc.sv
tests/memoryModel.sv
tests/miniSrcTb.sv

/* tests/memoryModel.sv */
module memoryModel (
    input  logic               clock,
    input  logic               rstN,
    input  logic               memReq,
    input  miniSrcPkg::memReqT memReqData,
    output logic               memAck,
    output miniSrcPkg::wordT   memRData,
    output logic               fault              // sticky protocol or address error.
);
    timeunit 1ns;
    timeprecision 100ps;
    import miniSrcPkg::*;

    wordT        mem [256];                     // byte address bits 9:2.
    logic [31:0] lfsr;
    logic        busy;                          // request seen, ack pending.
    int          waitLeft;
    memReqT      held;                          // request as first seen.

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32, 22, 2, 1.
    endfunction

    // two lfsr bits, 0 to 3 wait cycles.
    task automatic drawWait(output int n);
        n = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsrStep(lfsr);
            n = n * 2 + lfsr[0];
        end
    endtask

    task automatic fillMemory();
        logic [7:0] idx;
        for (int i = 0; i < 256; i++) begin
            idx = i[7:0];
            mem[i] = {8'hee, idx, ~idx, idx ^ 8'h5a};   // never a valid opcode.
        end
    endtask

    task automatic writeWord(input int idx, input wordT w);
        mem[idx] = w;
    endtask

    initial begin
        lfsr     = 32'ha1f9_bb8a;
        memAck   = 1'b0;
        memRData = '0;
        fault    = 1'b0;
        busy     = 1'b0;
        waitLeft = 0;
        held     = '0;
    end

    always @(posedge clock) begin
        #1;
        if (!rstN) begin
            memAck = 1'b0;
            busy   = 1'b0;
        end else if (memAck) begin
            if (!memReq) begin
                memAck = 1'b0;                  // request dropped, close handshake.
            end
        end else if (memReq) begin
            if (!busy) begin
                busy = 1'b1;
                held = memReqData;
                drawWait(waitLeft);
            end
            if (memReqData !== held || memReqData.addr[31:10] != '0 ||
                memReqData.addr[1:0] != 2'b00) begin
                fault = 1'b1;                   // moved mid-request or out of range.
            end
            if (waitLeft == 0) begin
                if (held.write) begin
                    mem[held.addr[9:2]] = held.wData;
                end else begin
                    memRData = mem[held.addr[9:2]];
                end
                memAck = 1'b1;
                busy   = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

endmodule

/* tests/miniSrcTb.sv */
module miniSrcTb;
    timeunit 1ns;
    timeprecision 100ps;
    import miniSrcPkg::*;

    localparam int numCases  = 5;
    localparam int maxWords  = 12;
    localparam int maxOuts   = 6;
    localparam int runLimit  = 3000;            // cycles per program.
    localparam int haltWatch = 8;               // cycles watched after halt.

    logic   clock;
    logic   rstN;
    logic   memReq;
    memReqT memReqData;
    logic   memAck;
    wordT   memRData;
    wordT   inPort;
    wordT   outPort;
    logic   halted;
    logic   memFault;

    wordT progTable [numCases][maxWords];
    int   progLen   [numCases];
    wordT inTable   [numCases];
    wordT expTable  [numCases][maxOuts];        // outPort values in order.
    int   expLen    [numCases];
    logic haltTable [numCases];
    int   caseCount;

    miniSrc #(
        .pcReset ('0)
    ) miniSrc_i (
        .clock      (clock),
        .rstN       (rstN),
        .memReq     (memReq),
        .memReqData (memReqData),
        .memAck     (memAck),
        .memRData   (memRData),
        .inPort     (inPort),
        .outPort    (outPort),
        .halted     (halted)
    );

    memoryModel memory_i (
        .clock      (clock),
        .rstN       (rstN),
        .memReq     (memReq),
        .memReqData (memReqData),
        .memAck     (memAck),
        .memRData   (memRData),
        .fault      (memFault)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // instruction words built from the field layout.
    function automatic wordT encImm(input opcodeT op, input int ra, input int rb, input int c);
        return {op, ra[3:0], rb[3:0], c[18:0]};
    endfunction

    function automatic wordT encReg(input opcodeT op, input int ra, input int rb, input int rc);
        return {op, ra[3:0], rb[3:0], rc[3:0], 15'd0};
    endfunction

    function automatic wordT encBr(input int ra, input int cond, input int c);
        return {opBr, ra[3:0], 2'b00, cond[1:0], c[18:0]};   // cond 0 zero, 1 nonzero.
    endfunction

    function automatic wordT encRa(input opcodeT op, input int ra);
        return {op, ra[3:0], 23'd0};
    endfunction

    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failRun(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stopRun();
    endtask

    task automatic compareWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic newCase(input wordT inVal, input logic expHalt);
        caseCount++;
        inTable[caseCount - 1]   = inVal;
        haltTable[caseCount - 1] = expHalt;
        progLen[caseCount - 1]   = 0;
        expLen[caseCount - 1]    = 0;
    endtask

    task automatic addWord(input wordT w);
        progTable[caseCount - 1][progLen[caseCount - 1]] = w;
        progLen[caseCount - 1] += 1;
    endtask

    task automatic addExpect(input wordT w);
        expTable[caseCount - 1][expLen[caseCount - 1]] = w;
        expLen[caseCount - 1] += 1;
    endtask

    task automatic buildTable();
        caseCount = 0;
        newCase(32'h0, 1'b1);                   // immediates and r0 base rule.
        addWord(encImm(opLdi, 0, 0, 7));        // r0 = 7.
        addWord(encImm(opLdi, 1, 0, 5));        // base r0 reads 0, r1 = 5.
        addWord(encRa(opOut, 1));
        addWord(encImm(opAddi, 2, 0, 3));       // plain read of r0, 7 + 3.
        addWord(encRa(opOut, 2));
        addWord(encImm(opLdi, 3, 1, -2));       // 5 - 2.
        addWord(encRa(opOut, 3));
        addWord(encImm(opAndi, 4, 3, 6));
        addWord(encRa(opOut, 4));
        addWord(encImm(opOri, 5, 4, 32'h70));
        addWord(encRa(opOut, 5));
        addWord(encRa(opHalt, 0));
        addExpect(32'h5);
        addExpect(32'ha);
        addExpect(32'h3);
        addExpect(32'h2);
        addExpect(32'h72);
        newCase(32'h0, 1'b1);                   // register-register ops.
        addWord(encImm(opLdi, 1, 0, 32'h3c));
        addWord(encImm(opLdi, 2, 0, 32'h0f));
        addWord(encReg(opAdd, 3, 1, 2));
        addWord(encRa(opOut, 3));
        addWord(encReg(opSub, 4, 2, 1));        // goes negative.
        addWord(encRa(opOut, 4));
        addWord(encReg(opAnd, 5, 1, 2));
        addWord(encRa(opOut, 5));
        addWord(encReg(opOr, 6, 1, 2));
        addWord(encRa(opOut, 6));
        addWord(encRa(opHalt, 0));
        addExpect(32'h0000_004b);
        addExpect(32'hffff_ffd3);
        addExpect(32'h0000_000c);
        addExpect(32'h0000_003f);
        newCase(32'h0, 1'b1);                   // store then load.
        addWord(encImm(opLdi, 1, 0, 32'h200));
        addWord(encImm(opLdi, 2, 0, 32'h2a5c3));
        addWord(encImm(opSt, 2, 1, 8));         // mem[0x208].
        addWord(encImm(opLdi, 5, 0, 32'h11));
        addWord(encImm(opSt, 5, 0, 32'h20c));   // absolute through r0 base.
        addWord(encImm(opLd, 3, 1, 8));
        addWord(encRa(opOut, 3));
        addWord(encImm(opLd, 4, 0, 32'h20c));
        addWord(encRa(opOut, 4));
        addWord(encRa(opHalt, 0));
        addExpect(32'h0002_a5c3);
        addExpect(32'h0000_0011);
        newCase(32'h0, 1'b1);                   // branches taken and not taken.
        addWord(encImm(opLdi, 1, 0, 32'h21));
        addWord(encBr(1, 0, 4));                // brzr, falls through.
        addWord(encRa(opOut, 1));
        addWord(encBr(1, 1, 4));                // brnz, skips word 4.
        addWord(encRa(opOut, 0));
        addWord(encImm(opLdi, 2, 0, 32'h33));
        addWord(encBr(0, 0, 4));                // brzr on r0, skips word 7.
        addWord(encRa(opOut, 0));
        addWord(encRa(opOut, 2));
        addWord(encBr(0, 1, 4));                // brnz on r0, falls through.
        addWord(encRa(opOut, 1));
        addWord(encRa(opHalt, 0));
        addExpect(32'h21);
        addExpect(32'h33);
        addExpect(32'h21);
        newCase(32'hcafe_1234, 1'b1);           // input port and halt.
        addWord(encRa(opIn, 7));
        addWord(encRa(opOut, 7));
        addWord(encImm(opAddi, 8, 7, 1));
        addWord(encRa(opOut, 8));
        addWord(encRa(opHalt, 0));
        addWord(encRa(opOut, 0));               // must never run.
        addExpect(32'hcafe_1234);
        addExpect(32'hcafe_1235);
    endtask

    task automatic runCase(input int k);
        wordT lastOut;
        int   outIdx;
        int   cycles;
        @(posedge clock);
        #2;
        rstN   = 1'b0;
        inPort = inTable[k];
        memory_i.fillMemory();
        for (int i = 0; i < progLen[k]; i++) begin
            memory_i.writeWord(i, progTable[k][i]);
        end
        repeat (3) @(posedge clock);
        #2;
        rstN = 1'b1;
        compareBit("memReq", memReq, 1'b0);     // quiet right after reset.
        compareBit("halted", halted, 1'b0);
        compareWord("outPort", outPort, '0);
        lastOut = outPort;
        outIdx  = 0;
        for (cycles = 0; !halted; cycles++) begin
            if (cycles == runLimit) begin
                failRun($sformatf("case %0d timed out before halt", k));
            end
            @(posedge clock);
            #2;
            compareBit("memFault", memFault, 1'b0); // request held and in range.
            if (outPort !== lastOut) begin
                if (outIdx >= expLen[k]) begin
                    failRun($sformatf("case %0d: outPort changed more times than expected", k));
                end
                compareWord($sformatf("outPort[%0d]", outIdx), outPort, expTable[k][outIdx]);
                outIdx++;
                lastOut = outPort;
            end
        end
        if (outIdx != expLen[k]) begin
            failRun($sformatf("case %0d: only %0d of %0d outPort values seen",
                              k, outIdx, expLen[k]));
        end
        repeat (haltWatch) begin
            @(posedge clock);
            #2;
            compareBit("memReq", memReq, 1'b0); // no fetch after halt.
            compareBit("halted", halted, haltTable[k]);
            compareWord("outPort", outPort, lastOut);
        end
        $display("case %0d: %0d outputs checked in %0d cycles", k, outIdx, cycles);
    endtask

    initial begin
        rstN   = 1'b0;
        inPort = '0;
        buildTable();
        for (int k = 0; k < caseCount; k++) begin
            runCase(k);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* verilog/alu.sv */
module alu (
    input  miniSrcPkg::aluOpT op,
    input  miniSrcPkg::wordT  a,                // from y.
    input  miniSrcPkg::wordT  b,                // from bus.
    output miniSrcPkg::wordT  result,
    output logic              isZero
);
    import miniSrcPkg::*;

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluInc4: begin
                result = b + 32'd4;             // next pc.
            end
            aluPassB: begin
                result = b;                     // used for the branch test.
            end
            default: begin
                result = b;
            end
        endcase
    end

    assign isZero = (result == '0);             // feeds con.

endmodule

/* verilog/controlUnit.sv */
module controlUnit (
    input  logic               clock,
    input  logic               rstN,
    input  miniSrcPkg::instrT  ir,
    input  logic               con,
    output miniSrcPkg::ctrlT   ctrl,
    output logic               memReq,
    output logic               memWrite,
    output logic               memLoad,
    input  logic               memAck,
    output logic               halted
);
    import miniSrcPkg::*;

    typedef enum logic [3:0] {
        stReset, stT0, stT1, stT2, stT3, stT4, stT5, stT6, stT7, stMemWait, stHalt
    } stateT;

    stateT state;
    stateT retState;                            // where memWait resumes.
    logic  reqQ;
    logic  writeQ;

    function automatic aluOpT aluOpFor(input opcodeT op);
        case (op)
            opSub:         return aluSub;
            opAnd, opAndi: return aluAnd;
            opOr, opOri:   return aluOr;
            default:       return aluAdd;       // add, addi, ldi, ld, st.
        endcase
    endfunction

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state    <= stReset;
            retState <= stT0;
            reqQ     <= 1'b0;
            writeQ   <= 1'b0;
        end else begin
            case (state)
                stReset: state <= stT0;
                stT0:    state <= stT1;
                stT1: begin
                    state    <= stMemWait;      // instruction read.
                    retState <= stT2;
                    reqQ     <= 1'b1;
                    writeQ   <= 1'b0;
                end
                stT2: state <= stT3;
                stT3: begin
                    case (ir.opcode)
                        opIn, opOut, opNop: state <= stT0;
                        opHalt:             state <= stHalt;
                        opLd, opLdi, opSt, opAdd, opSub, opAnd, opOr,
                        opAddi, opAndi, opOri, opBr: state <= stT4;
                        default:            state <= stT0;
                    endcase
                end
                stT4: state <= stT5;
                stT5: begin
                    if (ir.opcode == opLd) begin
                        state    <= stMemWait;  // data read.
                        retState <= stT7;
                        reqQ     <= 1'b1;
                        writeQ   <= 1'b0;
                    end else if (ir.opcode == opSt || ir.opcode == opBr) begin
                        state <= stT6;
                    end else begin
                        state <= stT0;
                    end
                end
                stT6: begin
                    if (ir.opcode == opSt) begin
                        state    <= stMemWait;  // data write.
                        retState <= stT0;
                        reqQ     <= 1'b1;
                        writeQ   <= 1'b1;
                    end else begin
                        state <= stT0;
                    end
                end
                stT7: state <= stT0;
                stMemWait: begin
                    if (reqQ && memAck) begin
                        reqQ <= 1'b0;           // ack seen, drop request.
                    end else if (!reqQ && !memAck) begin
                        state <= retState;      // handshake closed.
                    end
                end
                stHalt:  state <= stHalt;
                default: state <= stReset;
            endcase
        end
    end

    always_comb begin
        ctrl    = '0;
        memLoad = 1'b0;
        case (state)
            stT0: begin
                ctrl.pcOut = 1'b1;              // pc to mar, z gets pc + 4.
                ctrl.marIn = 1'b1;
                ctrl.zIn   = 1'b1;
                ctrl.aluOp = aluInc4;
            end
            stT1: begin
                ctrl.zLowOut = 1'b1;
                ctrl.pcIn    = 1'b1;
            end
            stT2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn   = 1'b1;
            end
            stT3: begin
                case (ir.opcode)
                    opLd, opLdi, opSt: begin
                        ctrl.grb   = 1'b1;      // base into y.
                        ctrl.baOut = 1'b1;
                        ctrl.yIn   = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr, opAddi, opAndi, opOri: begin
                        ctrl.grb  = 1'b1;
                        ctrl.rOut = 1'b1;
                        ctrl.yIn  = 1'b1;
                    end
                    opBr: begin
                        ctrl.gra   = 1'b1;      // test ra.
                        ctrl.rOut  = 1'b1;
                        ctrl.conIn = 1'b1;
                        ctrl.aluOp = aluPassB;
                    end
                    opIn: begin
                        ctrl.inPortOut = 1'b1;
                        ctrl.gra       = 1'b1;
                        ctrl.rIn       = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra       = 1'b1;
                        ctrl.rOut      = 1'b1;
                        ctrl.outPortIn = 1'b1;
                    end
                    default: ;
                endcase
            end
            stT4: begin
                case (ir.opcode)
                    opAdd, opSub, opAnd, opOr: begin
                        ctrl.grc   = 1'b1;      // y op rc.
                        ctrl.rOut  = 1'b1;
                        ctrl.zIn   = 1'b1;
                        ctrl.aluOp = aluOpFor(ir.opcode);
                    end
                    opBr: begin
                        ctrl.pcOut = 1'b1;
                        ctrl.yIn   = 1'b1;
                    end
                    default: begin
                        ctrl.cOut  = 1'b1;      // y op c.
                        ctrl.zIn   = 1'b1;
                        ctrl.aluOp = aluOpFor(ir.opcode);
                    end
                endcase
            end
            stT5: begin
                if (ir.opcode == opLd || ir.opcode == opSt) begin
                    ctrl.zLowOut = 1'b1;        // effective address.
                    ctrl.marIn   = 1'b1;
                end else if (ir.opcode == opBr) begin
                    ctrl.cOut  = 1'b1;          // branch target.
                    ctrl.zIn   = 1'b1;
                    ctrl.aluOp = aluAdd;
                end else begin
                    ctrl.zLowOut = 1'b1;
                    ctrl.gra     = 1'b1;
                    ctrl.rIn     = 1'b1;
                end
            end
            stT6: begin
                if (ir.opcode == opSt) begin
                    ctrl.gra   = 1'b1;          // store data into mdr.
                    ctrl.rOut  = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end else begin
                    ctrl.zLowOut = con;         // taken only if con.
                    ctrl.pcIn    = con;
                end
            end
            stT7: begin
                ctrl.mdrOut = 1'b1;             // load result to ra.
                ctrl.gra    = 1'b1;
                ctrl.rIn    = 1'b1;
            end
            stMemWait: begin
                memLoad = reqQ && memAck && !writeQ;
            end
            default: ;
        endcase
    end

    assign memReq   = reqQ;
    assign memWrite = writeQ;
    assign halted   = (state == stHalt);

    // a new request only starts once the last ack has fallen.
    reqAfterAckLow: assert property (
        @(posedge clock) disable iff (!rstN)
        $rose(memReq) |-> !$past(memAck)
    ) else $error("controlUnit: request raised while ack high");

endmodule

/* verilog/datapath.sv */
module datapath #(
    parameter miniSrcPkg::wordT pcReset = '0
) (
    input  logic               clock,
    input  logic               rstN,
    input  miniSrcPkg::ctrlT   ctrl,
    input  miniSrcPkg::wordT   memRData,
    input  logic               memLoad,         // mdr from memory.
    input  miniSrcPkg::wordT   inPort,
    output miniSrcPkg::instrT  ir,
    output logic               con,
    output miniSrcPkg::wordT   memAddr,
    output miniSrcPkg::wordT   memWData,
    output miniSrcPkg::wordT   outPort
);
    import miniSrcPkg::*;

    wordT       bus;
    wordT       pc;
    wordT       y;
    wordT       z;
    wordT       mar;
    wordT       mdr;
    wordT       regData;
    wordT       aluResult;
    wordT       cExt;                           // sign-extended constant.
    logic       aluZero;
    logic [3:0] regSel;

    assign cExt = {{13{ir.c[18]}}, ir.c};

    // register number comes from the ir field picked by gra/grb/grc.
    always_comb begin
        if (ctrl.gra) begin
            regSel = ir.ra;
        end else if (ctrl.grb) begin
            regSel = ir.rb;
        end else if (ctrl.grc) begin
            regSel = ir.c[18:15];               // rc.
        end else begin
            regSel = 4'd0;
        end
    end

    registerFile regFile_i (
        .clock   (clock),
        .rstN    (rstN),
        .sel     (regSel),
        .writeEn (ctrl.rIn),
        .baMode  (ctrl.baOut),
        .wData   (bus),
        .rData   (regData)
    );

    // bus source, at most one out control per step.
    always_comb begin
        if (ctrl.rOut || ctrl.baOut) begin
            bus = regData;
        end else if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.cOut) begin
            bus = cExt;
        end else if (ctrl.zLowOut) begin
            bus = z;
        end else if (ctrl.inPortOut) begin
            bus = inPort;
        end else begin
            bus = '0;
        end
    end

    alu alu_i (
        .op     (ctrl.aluOp),
        .a      (y),
        .b      (bus),
        .result (aluResult),
        .isZero (aluZero)
    );

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc      <= pcReset;
            ir      <= '0;
            y       <= '0;
            z       <= '0;
            mar     <= '0;
            mdr     <= '0;
            con     <= 1'b0;
            outPort <= '0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.irIn) ir <= instrT'(bus);
            if (ctrl.yIn) y <= bus;
            if (ctrl.zIn) z <= aluResult;
            if (ctrl.marIn) mar <= bus;
            if (memLoad) begin
                mdr <= memRData;                // read data wins over bus.
            end else if (ctrl.mdrIn) begin
                mdr <= bus;
            end
            if (ctrl.conIn) begin
                case (ir.rb[1:0])
                    2'b00:   con <= aluZero;    // brzr.
                    2'b01:   con <= !aluZero;   // brnz.
                    default: con <= 1'b0;
                endcase
            end
            if (ctrl.outPortIn) outPort <= bus;
        end
    end

    assign memAddr  = mar;
    assign memWData = mdr;

    // the control unit never selects two bus sources at once.
    oneBusDriver: assert property (
        @(posedge clock) disable iff (!rstN)
        $onehot0({ctrl.rOut, ctrl.baOut, ctrl.pcOut, ctrl.mdrOut,
                  ctrl.cOut, ctrl.zLowOut, ctrl.inPortOut})
    ) else $error("datapath: bus contention");

endmodule

/* verilog/miniSrc.sv */
module miniSrc #(
    parameter miniSrcPkg::wordT pcReset = '0
) (
    input  logic                clock,
    input  logic                rstN,
    output logic                memReq,
    output miniSrcPkg::memReqT  memReqData,
    input  logic                memAck,
    input  miniSrcPkg::wordT    memRData,
    input  miniSrcPkg::wordT    inPort,
    output miniSrcPkg::wordT    outPort,
    output logic                halted
);
    import miniSrcPkg::*;

    ctrlT  ctrl;
    instrT ir;
    logic  con;
    logic  memWrite;
    logic  memLoad;                             // mdr strobe on read ack.
    wordT  memAddr;
    wordT  memWData;

    controlUnit control_i (
        .clock    (clock),
        .rstN     (rstN),
        .ir       (ir),
        .con      (con),
        .ctrl     (ctrl),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memLoad  (memLoad),
        .memAck   (memAck),
        .halted   (halted)
    );

    datapath #(
        .pcReset (pcReset)
    ) datapath_i (
        .clock    (clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memRData (memRData),
        .memLoad  (memLoad),
        .inPort   (inPort),
        .ir       (ir),
        .con      (con),
        .memAddr  (memAddr),
        .memWData (memWData),
        .outPort  (outPort)
    );

    // mar and mdr hold still for the whole handshake.
    assign memReqData = '{addr: memAddr, write: memWrite, wData: memWData};

endmodule

/* verilog/miniSrcPkg.sv */
package miniSrcPkg;

    typedef logic [31:0] wordT;                 // one bus word.

    typedef enum logic [4:0] {
        opLd   = 5'b00000,                      // ra <- mem[rb + c].
        opLdi  = 5'b00001,                      // ra <- rb + c.
        opSt   = 5'b00010,                      // mem[rb + c] <- ra.
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opBr   = 5'b10010,                      // brzr / brnz by condition field.
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opNop  = 5'b11010,
        opHalt = 5'b11011
    } opcodeT;

    // rc is c[18:15]; the branch condition is rb[1:0].
    typedef struct packed {
        opcodeT      opcode;                    // bits 31:27.
        logic [3:0]  ra;                        // bits 26:23.
        logic [3:0]  rb;                        // bits 22:19.
        logic [18:0] c;                         // signed constant.
    } instrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluInc4,                                // b + 4, pc increment.
        aluPassB                                // bus straight through.
    } aluOpT;

    typedef struct packed {
        logic  gra;                             // register select from ra.
        logic  grb;                             // register select from rb.
        logic  grc;                             // register select from rc.
        logic  rIn;
        logic  rOut;
        logic  baOut;                           // r0 reads zero.
        logic  pcOut;
        logic  pcIn;
        logic  mdrOut;
        logic  mdrIn;                           // mdr from bus.
        logic  cOut;                            // sign-extended constant.
        logic  yIn;
        logic  zIn;
        logic  zLowOut;
        logic  marIn;
        logic  irIn;
        logic  conIn;
        logic  inPortOut;
        logic  outPortIn;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        wordT addr;
        logic write;                            // 1 = store.
        wordT wData;
    } memReqT;

endpackage

/* verilog/registerFile.sv */
module registerFile (
    input  logic              clock,
    input  logic              rstN,
    input  logic [3:0]        sel,
    input  logic              writeEn,
    input  logic              baMode,
    input  miniSrcPkg::wordT  wData,
    output miniSrcPkg::wordT  rData
);
    import miniSrcPkg::*;

    wordT regs [16];                            // r0..r15.

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[sel] <= wData;                 // r0 is writable.
        end
    end

    // base-address read of r0 gives zero.
    assign rData = (baMode && sel == 4'd0) ? '0 : regs[sel];

    // baOut only ever reads, never in the same step as rIn.
    writeNotBase: assert property (
        @(posedge clock) disable iff (!rstN)
        !(writeEn && baMode)
    ) else $error("registerFile: write during base-address read");

endmodule
